// ==== include/m_ext_cfg.svh ====
`ifndef M_EXT_CFG_SVH
`define M_EXT_CFG_SVH

`define XLEN   32  // data word width
`define RTAG_W 5   // destination register index width

`endif

// ==== source/riscv_types.sv ====
`default_nettype none

`include "m_ext_cfg.svh"

package riscv_types;

    // operand or result word
    typedef logic [`XLEN-1:0] xlen_t;

    // destination register index that rides along with an operation
    typedef logic [`RTAG_W-1:0] rtag_t;

    // M-extension ops, values follow func3
    // bit 2 set means the op goes to the divider
    typedef enum logic [2:0] {
        MUL    = 3'd0,  // low half, sign does not matter
        MULH   = 3'd1,  // high half, signed x signed
        MULHSU = 3'd2,  // high half, signed x unsigned
        MULHU  = 3'd3,  // high half, unsigned x unsigned
        DIV    = 3'd4,  // signed quotient
        DIVU   = 3'd5,  // unsigned quotient
        REM    = 3'd6,  // signed remainder
        REMU   = 3'd7   // unsigned remainder
    } alu_t;

endpackage

`default_nettype wire

// ==== source/int_div_rem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_cfg.svh"

module int_div_rem #(
    parameter int WIDTH = `XLEN
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_flush,   // drop whatever is in flight
    input  logic               i_start,   // one-cycle pulse, refers to the operands of last cycle
    input  riscv_types::alu_t  i_op,
    input  riscv_types::xlen_t i_a,       // dividend
    input  riscv_types::xlen_t i_b,       // divisor
    output logic               o_busy,
    output logic               o_done,    // one-cycle pulse with the result
    output logic               o_dbz,     // divide by zero
    output logic               o_ovf,     // most negative / -1
    output riscv_types::xlen_t o_result
);

    localparam int CNT_W = $clog2(WIDTH);
    localparam logic [WIDTH-1:0] MOST_NEG = {1'b1, {(WIDTH-1){1'b0}}};

    typedef enum logic [1:0] {IDLE, INIT, CALC, FINALIZE} state_t;

    state_t            state;
    riscv_types::alu_t op_q;       // op held for the whole divide
    logic [WIDTH-1:0]  a_q;
    logic [WIDTH-1:0]  b_q;
    logic              is_signed;
    logic              is_rem;
    logic              a_neg;
    logic              b_neg;
    logic [WIDTH-1:0]  a_abs;
    logic [WIDTH-1:0]  b_abs;
    logic              is_dbz;
    logic              is_ovf;
    logic              dbz_q;
    logic              ovf_q;
    logic [WIDTH-1:0]  quo;        // dividend shifts out the top, quotient bits shift in
    logic [WIDTH-1:0]  rem;        // partial remainder
    logic [WIDTH:0]    shifted;
    logic [WIDTH:0]    diff;
    logic              fits;
    logic [WIDTH-1:0]  quo_fix;
    logic [WIDTH-1:0]  rem_fix;
    logic [CNT_W-1:0]  cnt;

    assign is_signed = (op_q == riscv_types::DIV) || (op_q == riscv_types::REM);
    assign is_rem    = op_q[1];                  // REM and REMU
    assign a_neg     = is_signed & a_q[WIDTH-1];
    assign b_neg     = is_signed & b_q[WIDTH-1];
    assign a_abs     = a_neg ? -a_q : a_q;
    assign b_abs     = b_neg ? -b_q : b_q;

    // special cases skip the loop entirely
    assign is_dbz = (b_q == '0);
    assign is_ovf = is_signed && (a_q == MOST_NEG) && (b_q == '1);

    // one restoring step
    assign shifted = {rem, quo[WIDTH-1]};
    assign diff    = shifted - {1'b0, b_abs};
    assign fits    = (shifted >= {1'b0, b_abs});

    // sign fix-up: quotient negative when signs differ, remainder follows dividend
    assign quo_fix = (a_neg ^ b_neg) ? -quo : quo;
    assign rem_fix = a_neg ? -rem : rem;

    assign o_busy = (state != IDLE);

    // operand register tracks the bus while idle, freezes once the start shows up
    always_ff @(posedge clk) begin
        if (state == IDLE && !i_start) begin
            a_q  <= i_a;
            b_q  <= i_b;
            op_q <= i_op;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            state <= IDLE;
            cnt   <= '0;
            dbz_q <= 1'b0;
            ovf_q <= 1'b0;
            o_done <= 1'b0;
            o_dbz  <= 1'b0;
            o_ovf  <= 1'b0;
        end else begin
            o_done <= 1'b0;  // pulse by default
            o_dbz  <= 1'b0;
            o_ovf  <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        dbz_q <= is_dbz;
                        ovf_q <= is_ovf;
                        state <= (is_dbz || is_ovf) ? FINALIZE : INIT;
                    end
                end
                INIT: begin
                    cnt   <= '0;
                    state <= CALC;
                end
                CALC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(WIDTH - 1)) begin
                        state <= FINALIZE;  // last quotient bit done
                    end
                end
                FINALIZE: begin
                    o_done <= 1'b1;
                    o_dbz  <= dbz_q;
                    o_ovf  <= ovf_q;
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            INIT: begin
                rem <= '0;
                quo <= a_abs;
            end
            CALC: begin
                quo <= {quo[WIDTH-2:0], fits};
                rem <= fits ? diff[WIDTH-1:0] : shifted[WIDTH-1:0];
            end
            FINALIZE: begin
                if (dbz_q) begin
                    o_result <= is_rem ? a_q : '1;  // x/0 = all ones, x%0 = x
                end else if (ovf_q) begin
                    o_result <= is_rem ? '0 : MOST_NEG;
                end else begin
                    o_result <= is_rem ? rem_fix : quo_fix;
                end
            end
            default: ;
        endcase
    end

    // issue stage must hold off a new divide until this one is out
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) i_start |-> !o_busy);

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) o_done |=> !o_done);

    // flags only travel with a result
    a_flag_with_done: assert property (@(posedge clk) disable iff (rst)
        (o_dbz || o_ovf) |-> o_done);

endmodule

`default_nettype wire

// ==== source/int_mul.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_cfg.svh"

module int_mul (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_flush,
    input  logic               i_start,   // one-cycle pulse, refers to the operands of last cycle
    input  riscv_types::alu_t  i_op,
    input  riscv_types::xlen_t i_a,
    input  riscv_types::xlen_t i_b,
    output logic               o_done,
    output riscv_types::xlen_t o_result
);

    localparam int W = `XLEN;

    riscv_types::alu_t     op_q;
    riscv_types::alu_t     op1;
    riscv_types::alu_t     op2;
    riscv_types::xlen_t    a_q;
    riscv_types::xlen_t    b_q;
    logic                  a_sgn;
    logic                  b_sgn;
    logic signed [W:0]     a1;         // 33-bit extended operands
    logic signed [W:0]     b1;
    logic signed [2*W+1:0] full_prod;
    logic [2*W-1:0]        prod;
    logic                  v1;
    logic                  v2;

    assign a_sgn     = (op_q == riscv_types::MULH) || (op_q == riscv_types::MULHSU);
    assign b_sgn     = (op_q == riscv_types::MULH);
    assign full_prod = a1 * b1;        // signed 33x33, top two bits are just sign

    // input register lines up with the registered start from the issue stage
    always_ff @(posedge clk) begin
        a_q  <= i_a;
        b_q  <= i_b;
        op_q <= i_op;
        // stage 1
        a1  <= {a_sgn & a_q[W-1], a_q};
        b1  <= {b_sgn & b_q[W-1], b_q};
        op1 <= op_q;
        // stage 2
        prod <= full_prod[2*W-1:0];
        op2  <= op1;
    end

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
        end else begin
            v1 <= i_start;
            v2 <= v1;
        end
    end

    assign o_done   = v2;
    assign o_result = (op2 == riscv_types::MUL) ? prod[W-1:0] : prod[2*W-1:W];  // low or high half

    // nothing survives a flush
    a_flush_clears: assert property (@(posedge clk) disable iff (rst) i_flush |=> (!v1 && !v2));

endmodule

`default_nettype wire

// ==== source/m_ext_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module m_ext_issue (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_flush,
    input  logic               i_valid,
    input  riscv_types::alu_t  i_op,
    input  riscv_types::rtag_t i_rd,
    input  logic               i_div_busy,
    input  logic               i_mul_done,
    input  logic               i_div_done,
    input  riscv_types::xlen_t i_mul_result,
    input  riscv_types::xlen_t i_div_result,
    input  logic               i_div_dbz,
    input  logic               i_div_ovf,
    output logic               o_mul_start,
    output logic               o_div_start,
    output logic               o_busy,
    output logic               o_valid,
    output riscv_types::xlen_t o_result,
    output riscv_types::rtag_t o_rd,
    output logic               o_dbz,
    output logic               o_ovf
);

    logic               accept;
    logic               mul_inflight;
    logic               div_hold;
    logic [1:0]         line_v;        // tag line valid, follows the multiplier stages
    riscv_types::rtag_t start_rd;      // tag that goes with the registered start
    riscv_types::rtag_t line_rd [0:1];
    riscv_types::rtag_t div_rd;

    assign mul_inflight = o_mul_start | line_v[0] | line_v[1];
    assign div_hold     = i_valid & i_op[2] & mul_inflight;  // let multiplies drain first

    // busy covers the whole divide, up to the edge that raises o_valid
    assign o_busy = i_div_busy | o_div_start | i_div_done | div_hold;
    assign accept = i_valid & ~o_busy;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            o_mul_start <= 1'b0;
            o_div_start <= 1'b0;
            line_v      <= '0;
            o_valid     <= 1'b0;
            o_dbz       <= 1'b0;
            o_ovf       <= 1'b0;
        end else begin
            o_mul_start <= accept & ~i_op[2];
            o_div_start <= accept & i_op[2];
            line_v      <= {line_v[0], o_mul_start};
            o_valid     <= i_mul_done | i_div_done;
            o_dbz       <= i_div_done & i_div_dbz;
            o_ovf       <= i_div_done & i_div_ovf;
        end
    end

    always_ff @(posedge clk) begin
        start_rd   <= i_rd;
        line_rd[0] <= start_rd;
        line_rd[1] <= line_rd[0];      // lines up with i_mul_done
        if (accept && i_op[2]) begin
            div_rd <= i_rd;
        end
        o_result <= i_div_done ? i_div_result : i_mul_result;
        o_rd     <= i_div_done ? div_rd : line_rd[1];
    end

    // a divide never starts with a multiply in flight, so the two never finish together
    a_done_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_mul_done && i_div_done));

endmodule

`default_nettype wire

// ==== source/m_ext_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module m_ext_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_flush,
    input  logic               i_valid,
    input  riscv_types::alu_t  i_op,
    input  riscv_types::xlen_t i_a,
    input  riscv_types::xlen_t i_b,
    input  riscv_types::rtag_t i_rd,
    output logic               o_busy,
    output logic               o_valid,
    output riscv_types::xlen_t o_result,
    output riscv_types::rtag_t o_rd,
    output logic               o_dbz,
    output logic               o_ovf
);

    logic               mul_start;
    logic               div_start;
    logic               mul_done;
    logic               div_done;
    logic               div_busy;
    logic               div_dbz;
    logic               div_ovf;
    riscv_types::xlen_t mul_result;
    riscv_types::xlen_t div_result;

    m_ext_issue i_m_ext_issue (
        .clk          (clk),
        .rst          (rst),
        .i_flush      (i_flush),
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_rd         (i_rd),
        .i_div_busy   (div_busy),
        .i_mul_done   (mul_done),
        .i_div_done   (div_done),
        .i_mul_result (mul_result),
        .i_div_result (div_result),
        .i_div_dbz    (div_dbz),
        .i_div_ovf    (div_ovf),
        .o_mul_start  (mul_start),
        .o_div_start  (div_start),
        .o_busy       (o_busy),
        .o_valid      (o_valid),
        .o_result     (o_result),
        .o_rd         (o_rd),
        .o_dbz        (o_dbz),
        .o_ovf        (o_ovf)
    );

    // operands go straight to both units, each registers them itself
    int_mul i_int_mul (
        .clk      (clk),
        .rst      (rst),
        .i_flush  (i_flush),
        .i_start  (mul_start),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .o_done   (mul_done),
        .o_result (mul_result)
    );

    int_div_rem i_int_div_rem (
        .clk      (clk),
        .rst      (rst),
        .i_flush  (i_flush),
        .i_start  (div_start),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .o_busy   (div_busy),
        .o_done   (div_done),
        .o_dbz    (div_dbz),
        .o_ovf    (div_ovf),
        .o_result (div_result)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    initial o_clk = 1'b0;                    // first rising edge after half a period

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

// ==== tests/tb_m_ext_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "m_ext_cfg.svh"

module tb_m_ext_unit;

    localparam int XW           = `XLEN;
    localparam int MUL_LAT      = 3;          // acceptance edge to o_valid edge
    localparam int DIV_LAT      = 36;
    localparam int N_RAND_MUL   = 50;
    localparam int N_DIV_PAIRS  = 4;          // per divide op
    localparam int RESET_CYCLES = 10;
    localparam logic [31:0] SEED = 32'h9025_9c8d;
    localparam riscv_types::xlen_t MOST_NEG = {1'b1, {(XW-1){1'b0}}};
    localparam int WATCHDOG_CYCLES = RESET_CYCLES
        + (25 + N_RAND_MUL) * 4 + 10          // multiply stream
        + 4 * N_DIV_PAIRS * (DIV_LAT + 4)     // plain divides
        + 5 * (MUL_LAT + 5)                   // divide by zero
        + 4 * (DIV_LAT + 5)                   // overflow
        + 2 * DIV_LAT + 20                    // ordering
        + 4 * DIV_LAT + 40                    // flushes
        + 300;                                // margin

    logic               clk;
    logic               rst;
    logic               i_flush;
    logic               i_valid;
    riscv_types::alu_t  i_op;
    riscv_types::xlen_t i_a;
    riscv_types::xlen_t i_b;
    riscv_types::rtag_t i_rd;
    logic               o_busy;
    logic               o_valid;
    riscv_types::xlen_t o_result;
    riscv_types::rtag_t o_rd;
    logic               o_dbz;
    logic               o_ovf;

    int          cyc;                        // rising edges so far
    int          errors;
    int          checks;
    int          tests_run;
    logic [31:0] lfsr;
    riscv_types::xlen_t exp_res [$];         // expected results in issue order
    riscv_types::rtag_t exp_rd [$];
    logic               exp_dbz [$];
    logic               exp_ovf [$];
    int                 exp_edge [$];        // edge that should raise o_valid

    tb_clock #(.PERIOD_NS(100)) i_tb_clock (.o_clk(clk));

    m_ext_unit i_m_ext_unit (
        .clk      (clk),
        .rst      (rst),
        .i_flush  (i_flush),
        .i_valid  (i_valid),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .i_rd     (i_rd),
        .o_busy   (o_busy),
        .o_valid  (o_valid),
        .o_result (o_result),
        .o_rd     (o_rd),
        .o_dbz    (o_dbz),
        .o_ovf    (o_ovf)
    );

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    // one lfsr step per bit, low bits first
    function automatic riscv_types::xlen_t rand_bits(input int n);
        riscv_types::xlen_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            w[i] = lfsr[0];
        end
        return w;
    endfunction

    function automatic logic ref_dbz(input riscv_types::alu_t op, input riscv_types::xlen_t b);
        return op[2] && (b == '0);
    endfunction

    function automatic logic ref_ovf(input riscv_types::alu_t op, input riscv_types::xlen_t a,
                                     input riscv_types::xlen_t b);
        return (op == riscv_types::DIV || op == riscv_types::REM) && a == MOST_NEG && b == '1;
    endfunction

    // architectural result, from 64-bit products and the language's own division
    function automatic riscv_types::xlen_t ref_result(input riscv_types::alu_t op,
                                                      input riscv_types::xlen_t a,
                                                      input riscv_types::xlen_t b);
        logic [2*XW-1:0] ea;
        logic [2*XW-1:0] eb;
        logic [2*XW-1:0] prod;
        logic signed [XW-1:0] sa;
        logic signed [XW-1:0] sb;
        sa   = a;
        sb   = b;
        ea   = (op == riscv_types::MULH || op == riscv_types::MULHSU) ?
               {{XW{a[XW-1]}}, a} : {{XW{1'b0}}, a};
        eb   = (op == riscv_types::MULH) ? {{XW{b[XW-1]}}, b} : {{XW{1'b0}}, b};
        prod = ea * eb;                      // mod 2^64 is right for every sign mix
        case (op)
            riscv_types::MUL:  return prod[XW-1:0];
            riscv_types::DIV: begin
                if (b == '0) begin
                    return '1;
                end
                if (ref_ovf(op, a, b)) begin
                    return MOST_NEG;
                end
                return sa / sb;              // truncates toward zero, as RISC-V does
            end
            riscv_types::DIVU: return (b == '0) ? '1 : a / b;
            riscv_types::REM: begin
                if (b == '0) begin
                    return a;
                end
                if (ref_ovf(op, a, b)) begin
                    return '0;
                end
                return sa % sb;              // sign follows the dividend
            end
            riscv_types::REMU: return (b == '0) ? a : a % b;
            default:           return prod[2*XW-1:XW];  // the three high-half multiplies
        endcase
    endfunction

    function automatic int latency_of(input riscv_types::alu_t op, input riscv_types::xlen_t a,
                                      input riscv_types::xlen_t b);
        if (!op[2] || ref_dbz(op, b) || ref_ovf(op, a, b)) begin
            return MUL_LAT;                  // special divides skip the loop
        end
        return DIV_LAT;
    endfunction

    task automatic compare_word(input string name, input riscv_types::xlen_t got,
                                input riscv_types::xlen_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic compare_tag(input string name, input riscv_types::rtag_t got,
                               input riscv_types::rtag_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    task automatic check_output();
        int want_edge;
        if (exp_res.size() == 0) begin
            errors++;
            $display("%0t: o_valid raised with no operation outstanding", $time);
            return;
        end
        want_edge = exp_edge.pop_front();
        compare_word("o_result", o_result, exp_res.pop_front());
        compare_tag("o_rd", o_rd, exp_rd.pop_front());
        compare_flag("o_dbz", o_dbz, exp_dbz.pop_front());
        compare_flag("o_ovf", o_ovf, exp_ovf.pop_front());
        checks++;
        if (cyc != want_edge) begin
            errors++;
            $display("[FAIL] %0t o_valid edge got %0d expected %0d", $time, cyc, want_edge);
        end
    endtask

    // outputs settle after the rising edge, look at them half a cycle later
    always @(negedge clk) begin
        if (!rst && o_valid) begin
            check_output();
        end
    end

    // called right after a rising edge, returns on the edge that accepts the op
    task automatic issue_op(input riscv_types::alu_t op, input riscv_types::xlen_t a,
                            input riscv_types::xlen_t b, input riscv_types::rtag_t rd,
                            input bit track, output int acc_edge);
        int   waited;
        logic busy_seen;
        waited    = 0;
        busy_seen = 1'b1;
        i_valid <= 1'b1;
        i_op    <= op;
        i_a     <= a;
        i_b     <= b;
        i_rd    <= rd;
        while (busy_seen) begin
            @(negedge clk);
            busy_seen = o_busy;
            acc_edge  = cyc + 1;             // edge coming up
            @(posedge clk);
            waited++;
            if (busy_seen && waited > 2 * DIV_LAT) begin
                errors++;
                $display("%0t: %s for x%0d was never accepted", $time, op.name(), rd);
                acc_edge = -1;
                return;
            end
        end
        if (track) begin
            exp_res.push_back(ref_result(op, a, b));
            exp_rd.push_back(rd);
            exp_dbz.push_back(ref_dbz(op, b));
            exp_ovf.push_back(ref_ovf(op, a, b));
            exp_edge.push_back(acc_edge + latency_of(op, a, b));
        end
    endtask

    task automatic go_idle();
        i_valid <= 1'b0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int n;
        n = 0;
        while (exp_res.size() != 0 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (exp_res.size() != 0) begin
            errors++;
            $display("%0t: %0d expected results never appeared", $time, exp_res.size());
            exp_res.delete();
            exp_rd.delete();
            exp_dbz.delete();
            exp_ovf.delete();
            exp_edge.delete();
        end
        @(posedge clk);
    endtask

    // o_busy has to stay up for the whole divide
    task automatic watch_busy(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (!o_valid && n < max_cycles) begin
            compare_flag("o_busy", o_busy, 1'b1);
            @(negedge clk);
            n++;
        end
        @(posedge clk);
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - err_start);
    endtask

    task automatic test_mul();
        riscv_types::xlen_t corner [5];
        riscv_types::xlen_t a;
        riscv_types::xlen_t b;
        riscv_types::rtag_t rd;
        int acc;
        int err_start;
        err_start = errors;
        corner    = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        rd        = '0;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                for (int k = 0; k < 4; k++) begin
                    issue_op(riscv_types::alu_t'(3'(k)), corner[i], corner[j], rd, 1'b1, acc);
                    rd++;                     // tag tells the results apart
                end
            end
        end
        for (int n = 0; n < N_RAND_MUL; n++) begin
            a = rand_bits(XW);
            b = rand_bits(XW);
            for (int k = 0; k < 4; k++) begin
                issue_op(riscv_types::alu_t'(3'(k)), a, b, rd, 1'b1, acc);
                rd++;
            end
        end
        go_idle();
        wait_drain(MUL_LAT + 4);
        finish_test("multiply", err_start);
    endtask

    task automatic test_div();
        riscv_types::xlen_t a;
        riscv_types::xlen_t b;
        int acc;
        int err_start;
        err_start = errors;
        for (int k = 4; k < 8; k++) begin
            for (int n = 0; n < N_DIV_PAIRS; n++) begin
                a = rand_bits(XW);
                b = rand_bits((n % 2 == 1) ? 12 : XW);  // some small divisors too
                if (b == '0) begin
                    b = 1;
                end
                issue_op(riscv_types::alu_t'(3'(k)), a, b, 5'(k + n), 1'b1, acc);
                go_idle();
                watch_busy(DIV_LAT + 4);
                wait_drain(2);
            end
        end
        finish_test("divide", err_start);
    endtask

    task automatic test_div_zero();
        int acc;
        int err_start;
        err_start = errors;
        for (int k = 4; k < 8; k++) begin
            issue_op(riscv_types::alu_t'(3'(k)), rand_bits(XW), '0, 5'(k), 1'b1, acc);
            go_idle();
            wait_drain(MUL_LAT + 3);
        end
        issue_op(riscv_types::DIV, MOST_NEG, '0, 5'd9, 1'b1, acc);  // zero wins over overflow
        go_idle();
        wait_drain(MUL_LAT + 3);
        finish_test("divide_by_zero", err_start);
    endtask

    task automatic test_overflow();
        riscv_types::alu_t ops [4];
        int acc;
        int err_start;
        err_start = errors;
        ops = '{riscv_types::DIV, riscv_types::REM, riscv_types::DIVU, riscv_types::REMU};
        for (int k = 0; k < 4; k++) begin
            issue_op(ops[k], MOST_NEG, '1, 5'(20 + k), 1'b1, acc);  // unsigned ones divide normally
            go_idle();
            wait_drain(DIV_LAT + 4);
        end
        finish_test("overflow", err_start);
    endtask

    task automatic test_order();
        riscv_types::xlen_t a;
        riscv_types::xlen_t b;
        int acc_m1;
        int acc_m2;
        int acc_d;
        int acc_m3;
        int err_start;
        err_start = errors;
        a = rand_bits(XW);
        b = rand_bits(XW) | 1;               // nonzero divisor
        issue_op(riscv_types::MUL, a, b, 5'd1, 1'b1, acc_m1);
        issue_op(riscv_types::MULHU, a, b, 5'd2, 1'b1, acc_m2);
        issue_op(riscv_types::DIVU, a, b, 5'd3, 1'b1, acc_d);
        issue_op(riscv_types::MULH, a, b, 5'd4, 1'b1, acc_m3);  // held behind the divide
        go_idle();
        wait_drain(DIV_LAT + 6);
        if (acc_d <= acc_m2 + MUL_LAT) begin
            errors++;
            $display("divide accepted at edge %0d, before the multiply result at edge %0d",
                     acc_d, acc_m2 + MUL_LAT);
        end
        if (acc_m3 <= acc_d + DIV_LAT) begin
            errors++;
            $display("held multiply accepted at edge %0d, before the divide result at edge %0d",
                     acc_m3, acc_d + DIV_LAT);
        end
        finish_test("ordering", err_start);
    endtask

    task automatic test_flush();
        int acc;
        int err_start;
        err_start = errors;
        issue_op(riscv_types::DIV, rand_bits(XW), rand_bits(XW) | 1, 5'd7, 1'b0, acc);
        go_idle();
        repeat (10) @(posedge clk);          // well inside CALC
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
        @(negedge clk);
        compare_flag("o_busy", o_busy, 1'b0);
        repeat (DIV_LAT + 4) @(posedge clk); // any o_valid now is caught by the monitor
        issue_op(riscv_types::REMU, rand_bits(XW), rand_bits(XW) | 1, 5'd8, 1'b1, acc);
        go_idle();
        wait_drain(DIV_LAT + 4);
        issue_op(riscv_types::MUL, rand_bits(XW), rand_bits(XW), 5'd10, 1'b0, acc);
        issue_op(riscv_types::MULH, rand_bits(XW), rand_bits(XW), 5'd11, 1'b0, acc);
        go_idle();
        i_flush <= 1'b1;                     // both still in the pipeline
        @(posedge clk);
        i_flush <= 1'b0;
        @(negedge clk);
        compare_flag("o_busy", o_busy, 1'b0);
        repeat (MUL_LAT + 4) @(posedge clk);
        issue_op(riscv_types::MULHSU, rand_bits(XW), rand_bits(XW), 5'd12, 1'b1, acc);
        go_idle();
        wait_drain(MUL_LAT + 4);
        finish_test("flush", err_start);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst       = 1'b1;
        i_flush   = 1'b0;
        i_valid   = 1'b0;
        i_op      = riscv_types::MUL;
        i_a       = '0;
        i_b       = '0;
        i_rd      = '0;
        cyc       = 0;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        lfsr      = SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        test_mul();
        test_div();
        test_div_zero();
        test_overflow();
        test_order();
        test_flush();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
source/riscv_types.sv
source/int_div_rem.sv
source/int_mul.sv
source/m_ext_issue.sv
source/m_ext_unit.sv
tests/tb_clock.sv
tests/tb_m_ext_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_m_ext_unit
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# a crashed or aborted simulation counts as a failure as well
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
